//--- common/regmgr_defines.svh
`ifndef REGMGR_DEFINES_SVH
`define REGMGR_DEFINES_SVH

// data word and memory address width
`define REGMGR_DATA_W 32
// register slot number width
`define REGMGR_SLOT_W 4

// enum widths
`define REGMGR_OP_W    3
`define REGMGR_STEP_W  2
`define REGMGR_STATE_W 3

// command encodings
`define REGMGR_OP_CATCH   3'd0
`define REGMGR_OP_READ    3'd1
`define REGMGR_OP_READ_P  3'd2
`define REGMGR_OP_WRITE   3'd3
`define REGMGR_OP_WRITE_P 3'd4

// post-step encodings, 01 is increment and 10 is decrement
`define REGMGR_STEP_NONE 2'b00
`define REGMGR_STEP_INC  2'b01
`define REGMGR_STEP_DEC  2'b10

`endif

//--- common/regmgr_pkg.sv
`include "regmgr_defines.svh"

package regmgr_pkg;

  // memory word or register value
  typedef logic [`REGMGR_DATA_W-1:0] data_t;

  // memory address, same width as data
  typedef logic [`REGMGR_DATA_W-1:0] addr_t;

  // register slot number
  typedef logic [`REGMGR_SLOT_W-1:0] slot_t;

  // post-step applied to the word written by op_write
  typedef enum logic [`REGMGR_STEP_W-1:0] {
    step_none = `REGMGR_STEP_NONE,
    step_inc  = `REGMGR_STEP_INC,
    step_dec  = `REGMGR_STEP_DEC
  } step_t;

  // command kinds
  typedef enum logic [`REGMGR_OP_W-1:0] {
    op_catch   = `REGMGR_OP_CATCH,
    op_read    = `REGMGR_OP_READ,
    op_read_p  = `REGMGR_OP_READ_P,
    op_write   = `REGMGR_OP_WRITE,
    op_write_p = `REGMGR_OP_WRITE_P
  } reg_op_t;

  // command FSM states
  typedef enum logic [`REGMGR_STATE_W-1:0] {
    st_idle     = 3'd0,
    st_req      = 3'd1,
    st_wait_rsp = 3'd2,
    st_done     = 3'd3
  } fsm_state_t;

endpackage

//--- common/reg_ctrl_if.sv
`timescale 1ns/1ps

// steering strobes from the command FSM to the operand latches
interface reg_ctrl_if;

  // load value from the command word
  // pointer loads too on a pointer catch
  logic catch_en;

  // slot read returned, load value and pointer
  logic read_slot_en;

  // read through pointer returned, value only
  logic read_ptr_en;

  // latch step and is_ptr of the accepted command
  logic capture_cmd;

  modport ctrl (
    output catch_en,
    output read_slot_en,
    output read_ptr_en,
    output capture_cmd
  );

  modport regs (
    input catch_en,
    input read_slot_en,
    input read_ptr_en,
    input capture_cmd
  );

endinterface

//--- source/regmgr_fsm.sv
`timescale 1ns/1ps
`include "regmgr_defines.svh"

module regmgr_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  input  regmgr_pkg::reg_op_t cmd_op,
  output logic                cmd_ready,
  input  logic                mem_req_ready,
  input  logic                mem_rsp_valid,
  output logic                mem_req_valid,
  output logic                mem_we,
  output logic                op_done,
  output logic                use_ptr_addr,
  reg_ctrl_if.ctrl            ctrl
);
  import regmgr_pkg::*;

  fsm_state_t state;
  fsm_state_t state_nxt;
  reg_op_t    op_q;
  logic       accept;
  logic       cmd_needs_mem;
  logic       op_is_read;
  logic       op_is_write;
  logic       rsp_hit;

  // one command in flight, new ones only while idle
  assign cmd_ready = (state == st_idle);
  assign accept    = cmd_valid && cmd_ready;

  // anything but a memory op finishes like a catch
  assign cmd_needs_mem = (cmd_op == op_read) || (cmd_op == op_read_p) ||
                         (cmd_op == op_write) || (cmd_op == op_write_p);

  // decode of the latched command kind
  assign op_is_read  = (op_q == op_read) || (op_q == op_read_p);
  assign op_is_write = (op_q == op_write) || (op_q == op_write_p);

  // pointer-based ops take the pointer as raw address
  assign use_ptr_addr = (op_q == op_read_p) || (op_q == op_write_p);

  // request is held for the whole of st_req
  // address and data stay stable since the latches only move on loads
  assign mem_req_valid = (state == st_req);
  assign mem_we        = mem_req_valid && op_is_write;

  // completion pulse, one cycle
  assign op_done = (state == st_done);

  // response only counts while we wait for one
  assign rsp_hit = (state == st_wait_rsp) && mem_rsp_valid;

  // step and is_ptr latched on every accepted command
  assign ctrl.capture_cmd = accept;

  // catch loads straight from the command word at acceptance
  assign ctrl.catch_en = accept && !cmd_needs_mem;

  // read data lands on the response cycle
  assign ctrl.read_slot_en = rsp_hit && (op_q == op_read);
  assign ctrl.read_ptr_en  = rsp_hit && (op_q == op_read_p);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (accept) begin
          // catch is done in the next cycle
          state_nxt = cmd_needs_mem ? st_req : st_done;
        end
      end
      st_req: begin
        // stalls here for as long as memory holds ready low
        if (mem_req_ready) begin
          state_nxt = op_is_read ? st_wait_rsp : st_done;
        end
      end
      st_wait_rsp: begin
        // no ready on the response, wait as long as it takes
        if (mem_rsp_valid) begin
          state_nxt = st_done;
        end
      end
      st_done: begin
        state_nxt = st_idle;
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      op_q  <= op_catch;
    end else begin
      state <= state_nxt;
      // command kind kept for the rest of the transaction
      if (accept) begin
        op_q <= cmd_op;
      end
    end
  end

endmodule

//--- source/addr_translate.sv
`timescale 1ns/1ps
`include "regmgr_defines.svh"

module addr_translate (
  input  regmgr_pkg::slot_t slot,
  input  regmgr_pkg::addr_t pointer,
  input  logic              use_ptr_addr,
  input  regmgr_pkg::addr_t base_code,
  input  regmgr_pkg::addr_t base_data,
  input  regmgr_pkg::addr_t data_start,
  input  regmgr_pkg::addr_t fixed_start,
  output regmgr_pkg::addr_t phys_addr
);
  import regmgr_pkg::*;

  addr_t slot_addr;
  addr_t raw_addr;
  addr_t base_sel;

  // slot number zero-extended to a full address
  assign slot_addr = {{(`REGMGR_DATA_W - `REGMGR_SLOT_W){1'b0}}, slot};

  // raw address before translation
  assign raw_addr = use_ptr_addr ? pointer : slot_addr;

  // three regions, checked from the top down
  always_comb begin
    if (raw_addr >= fixed_start) begin
      // fixed region, used as it is
      base_sel = '0;
    end else if (raw_addr >= data_start) begin
      // data region
      base_sel = base_data;
    end else begin
      // everything below the data boundary is code
      base_sel = base_code;
    end
  end

  // wraps modulo 2^32 like the bus does
  assign phys_addr = raw_addr + base_sel;

endmodule

//--- source/operand_regs.sv
`timescale 1ns/1ps
`include "regmgr_defines.svh"

module operand_regs (
  input  logic              clk,
  input  logic              rst,
  input  regmgr_pkg::data_t cmd_value,
  input  regmgr_pkg::data_t mem_rdata,
  input  regmgr_pkg::step_t cmd_step,
  input  logic              cmd_is_ptr,
  input  logic              cmd_write_p,
  reg_ctrl_if.regs          regs,
  output regmgr_pkg::data_t value,
  output regmgr_pkg::data_t pointer,
  output regmgr_pkg::data_t wdata
);
  import regmgr_pkg::*;

  step_t step_q;
  logic  is_ptr_q;
  logic  write_p_q;
  data_t save_word;
  data_t stepped_word;

  always_ff @(posedge clk) begin
    if (rst) begin
      value     <= '0;
      pointer   <= '0;
      step_q    <= step_none;
      is_ptr_q  <= 1'b0;
      write_p_q <= 1'b0;
    end else begin
      // command modifiers, held until the next acceptance
      if (regs.capture_cmd) begin
        step_q    <= cmd_step;
        is_ptr_q  <= cmd_is_ptr;
        write_p_q <= cmd_write_p;
      end

      // at most one load strobe is high in a cycle
      if (regs.catch_en) begin
        value <= cmd_value;
        // pointer catch sets the pointer as well
        // uses the live is_ptr, the latched copy updates on this same edge
        if (cmd_is_ptr) begin
          pointer <= cmd_value;
        end
      end else if (regs.read_slot_en) begin
        // slot word is both the value and the pointer
        value   <= mem_rdata;
        pointer <= mem_rdata;
      end else if (regs.read_ptr_en) begin
        // indirect read, pointer untouched
        value <= mem_rdata;
      end
    end
  end

  // word chosen for a slot write
  assign save_word = is_ptr_q ? pointer : value;

  // post-step on the stored word only, latches keep their contents
  always_comb begin
    case (step_q)
      step_inc: stepped_word = save_word + 1'b1;
      step_dec: stepped_word = save_word - 1'b1;
      default:  stepped_word = save_word;
    endcase
  end

  // write through pointer stores the plain value
  assign wdata = write_p_q ? value : stepped_word;

endmodule

//--- source/regmgr_top.sv
`timescale 1ns/1ps
`include "regmgr_defines.svh"

module regmgr_top (
  input  logic                clk,
  input  logic                rst,
  // command channel
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  regmgr_pkg::reg_op_t cmd_op,
  input  regmgr_pkg::slot_t   cmd_slot,
  input  regmgr_pkg::step_t   cmd_step,
  input  logic                cmd_is_ptr,
  input  regmgr_pkg::data_t   cmd_value,
  // completion
  output logic                op_done,
  // region setup, stable while a command runs
  input  regmgr_pkg::addr_t   base_code,
  input  regmgr_pkg::addr_t   base_data,
  input  regmgr_pkg::addr_t   data_start,
  input  regmgr_pkg::addr_t   fixed_start,
  // memory request channel
  output logic                mem_req_valid,
  input  logic                mem_req_ready,
  output logic                mem_we,
  output regmgr_pkg::addr_t   mem_addr,
  output regmgr_pkg::data_t   mem_wdata,
  // memory read response
  input  logic                mem_rsp_valid,
  input  regmgr_pkg::data_t   mem_rdata,
  // observed registers
  output regmgr_pkg::data_t   value,
  output regmgr_pkg::data_t   pointer
);
  import regmgr_pkg::*;

  reg_ctrl_if u_ctrl_if ();

  slot_t slot_q;
  logic  use_ptr_addr;
  logic  cmd_write_p;
  addr_t phys_addr;
  data_t wdata;

  // slot number kept for the request phase
  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      slot_q <= cmd_slot;
    end
  end

  // write-through-pointer flag, latched with step and is_ptr
  assign cmd_write_p = (cmd_op == op_write_p);

  regmgr_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_ready     (cmd_ready),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_req_valid (mem_req_valid),
    .mem_we        (mem_we),
    .op_done       (op_done),
    .use_ptr_addr  (use_ptr_addr),
    .ctrl          (u_ctrl_if.ctrl)
  );

  addr_translate u_addr (
    .slot         (slot_q),
    .pointer      (pointer),
    .use_ptr_addr (use_ptr_addr),
    .base_code    (base_code),
    .base_data    (base_data),
    .data_start   (data_start),
    .fixed_start  (fixed_start),
    .phys_addr    (phys_addr)
  );

  operand_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .cmd_value   (cmd_value),
    .mem_rdata   (mem_rdata),
    .cmd_step    (cmd_step),
    .cmd_is_ptr  (cmd_is_ptr),
    .cmd_write_p (cmd_write_p),
    .regs        (u_ctrl_if.regs),
    .value       (value),
    .pointer     (pointer),
    .wdata       (wdata)
  );

  // request fields straight from the datapath
  assign mem_addr  = phys_addr;
  assign mem_wdata = wdata;

endmodule

//--- bench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  input  logic                cmd_ready,
  input  regmgr_pkg::reg_op_t cmd_op,
  input  regmgr_pkg::slot_t   cmd_slot,
  input  regmgr_pkg::step_t   cmd_step,
  input  logic                cmd_is_ptr,
  input  regmgr_pkg::data_t   cmd_value,
  input  logic                op_done,
  input  regmgr_pkg::addr_t   base_code,
  input  regmgr_pkg::addr_t   base_data,
  input  regmgr_pkg::addr_t   data_start,
  input  regmgr_pkg::addr_t   fixed_start,
  input  logic                mem_req_valid,
  input  logic                mem_req_ready,
  input  logic                mem_we,
  input  regmgr_pkg::addr_t   mem_addr,
  input  regmgr_pkg::data_t   mem_wdata,
  input  logic                mem_rsp_valid,
  input  regmgr_pkg::data_t   value,
  input  regmgr_pkg::data_t   pointer,
  output int                  err_count,
  output int                  done_count
);
  import regmgr_pkg::*;

  data_t   shadow [addr_t];
  data_t   exp_value;
  data_t   exp_pointer;
  data_t   rd_word;
  reg_op_t cur_op;
  slot_t   cur_slot;
  step_t   cur_step;
  logic    cur_is_ptr;
  logic    busy;
  logic    req_seen;
  logic    done_due;
  logic    rst_prev;
  logic    held;
  logic    held_we;
  addr_t   held_addr;
  data_t   held_wdata;
  int      test_num;
  int      test_err_base;

  initial begin
    err_count  = 0;
    done_count = 0;
    test_num   = 0;
  end

  // expected address by the three-way region rule
  function automatic addr_t expect_addr(addr_t raw);
    if (raw >= fixed_start) return raw;
    else if (raw >= data_start) return raw + base_data;
    return raw + base_code;
  endfunction

  // expected write word with post-step
  function automatic data_t expect_wdata(reg_op_t op, data_t v, data_t p, step_t s, logic ip);
    data_t w;
    if (op == op_write_p) return v;
    w = ip ? p : v;
    if (s == step_inc) w = w + 1;
    else if (s == step_dec) w = w - 1;
    return w;
  endfunction

  // untouched words hold address xor pattern
  function automatic data_t shadow_read(addr_t a);
    if (shadow.exists(a)) return shadow[a];
    return a ^ 32'h5a5a0000;
  endfunction

  task automatic report_mismatch(string field, data_t exp, data_t act);
    err_count++;
    $display("CHECK FAILED test %0d %s %s: expected %h actual %h",
             test_num, cur_op.name(), field, exp, act);
  endtask

  task automatic report_error(string msg);
    err_count++;
    $display("error in test %0d: %s", test_num, msg);
  endtask

  task automatic check_request();
    addr_t raw;
    addr_t exp_a;
    data_t w;
    logic  is_wr;
    raw   = (cur_op == op_read_p || cur_op == op_write_p) ? exp_pointer : addr_t'(cur_slot);
    exp_a = expect_addr(raw);
    is_wr = (cur_op == op_write || cur_op == op_write_p);
    if (req_seen) report_error("second memory request in one command");
    req_seen = 1'b1;
    if (mem_addr !== exp_a) report_mismatch("mem_addr", exp_a, mem_addr);
    if (mem_we !== is_wr) report_mismatch("mem_we", data_t'(is_wr), data_t'(mem_we));
    if (is_wr) begin
      w = expect_wdata(cur_op, exp_value, exp_pointer, cur_step, cur_is_ptr);
      if (mem_wdata !== w) report_mismatch("mem_wdata", w, mem_wdata);
      shadow[exp_a] = w;
      // write ends one cycle after its handshake
      done_due = 1'b1;
    end else begin
      rd_word = shadow_read(exp_a);
    end
  endtask

  task automatic finish_test();
    if (cur_op != op_catch && !req_seen) report_error("command ended without a memory request");
    // read data lands in the latches
    if (cur_op == op_read || cur_op == op_read_p) exp_value = rd_word;
    if (cur_op == op_read) exp_pointer = rd_word;
    if (value !== exp_value) report_mismatch("value", exp_value, value);
    if (pointer !== exp_pointer) report_mismatch("pointer", exp_pointer, pointer);
    done_count++;
    busy = 1'b0;
    $display("test %0d %s slot %0d: %s", test_num, cur_op.name(), cur_slot,
             (err_count == test_err_base) ? "ok" : "mismatch");
  endtask

  always @(posedge clk) begin
    if (rst) begin
      rst_prev    = 1'b1;
      busy        = 1'b0;
      held        = 1'b0;
      done_due    = 1'b0;
      exp_value   = '0;
      exp_pointer = '0;
    end else begin
      // state right after reset
      if (rst_prev) begin
        if (cmd_ready !== 1'b1) report_error("cmd_ready low after reset");
        if (op_done !== 1'b0 || mem_req_valid !== 1'b0 || mem_we !== 1'b0)
          report_error("op_done or memory request active after reset");
        if (value !== '0) report_mismatch("value after reset", '0, value);
        if (pointer !== '0) report_mismatch("pointer after reset", '0, pointer);
        rst_prev = 1'b0;
      end
      // ready only while no command is in flight
      if (cmd_ready !== !busy) report_error("cmd_ready does not match the command state");
      // request fields held while ready is low
      if (held) begin
        if (!mem_req_valid) report_error("memory request dropped before ready");
        else if (mem_addr !== held_addr || mem_we !== held_we ||
                 (held_we && mem_wdata !== held_wdata))
          report_error("memory request fields changed while waiting for ready");
      end
      held       = mem_req_valid && !mem_req_ready;
      held_addr  = mem_addr;
      held_we    = mem_we;
      held_wdata = mem_wdata;
      // op_done exactly one cycle after catch, write handshake or read response
      if (done_due && !op_done) report_error("op_done missing in the cycle after the command ended");
      if (op_done && !done_due) report_error("op_done before the command ended");
      done_due = 1'b0;
      if (mem_req_valid && mem_req_ready) begin
        if (!busy) report_error("memory request with no command in flight");
        else check_request();
      end
      if (mem_rsp_valid && busy && req_seen &&
          (cur_op == op_read || cur_op == op_read_p)) begin
        done_due = 1'b1;
      end
      if (op_done) begin
        if (!busy) report_error("op_done with no command in flight");
        else finish_test();
      end
      if (cmd_valid && cmd_ready) begin
        test_num++;
        test_err_base = err_count;
        cur_op        = cmd_op;
        cur_slot      = cmd_slot;
        cur_step      = cmd_step;
        cur_is_ptr    = cmd_is_ptr;
        busy          = 1'b1;
        req_seen      = 1'b0;
        if (cmd_op == op_catch) begin
          done_due  = 1'b1;
          exp_value = cmd_value;
          if (cmd_is_ptr) exp_pointer = cmd_value;
        end
      end
    end
  end

endmodule

//--- bench/tb_regmgr_top.sv
`timescale 1ns/1ps

module tb_regmgr_top;
  import regmgr_pkg::*;

  localparam int WAIT_LIMIT = 400;

  logic    clk = 1'b0;
  logic    rst;
  logic    cmd_valid;
  logic    cmd_ready;
  reg_op_t cmd_op;
  slot_t   cmd_slot;
  step_t   cmd_step;
  logic    cmd_is_ptr;
  data_t   cmd_value;
  logic    op_done;
  addr_t   base_code;
  addr_t   base_data;
  addr_t   data_start;
  addr_t   fixed_start;
  logic    mem_req_valid;
  logic    mem_req_ready;
  logic    mem_we;
  addr_t   mem_addr;
  data_t   mem_wdata;
  logic    mem_rsp_valid;
  data_t   mem_rdata;
  data_t   value;
  data_t   pointer;
  int      err_count;
  int      done_count;
  int      issued = 0;
  logic    timed_out = 1'b0;

  // separate streams for stimulus and memory timing
  int unsigned stim_seed = 75322;
  int unsigned mem_seed  = 75322;
  data_t       mem [addr_t];
  data_t       rsp_q [$];
  int          rsp_delay = 0;

  always #2 clk = ~clk;

  regmgr_top u_dut (.*);

  tb_checker u_chk (.*);

  function automatic int unsigned lcg_step(ref int unsigned s);
    s = s * 32'd1103515245 + 32'd12345;
    return s >> 8;
  endfunction

  function automatic data_t rand_word();
    data_t w;
    w[31:16] = lcg_step(stim_seed);
    w[15:0]  = lcg_step(stim_seed);
    return w;
  endfunction

  function automatic data_t mem_read(addr_t a);
    if (mem.exists(a)) return mem[a];
    return a ^ 32'h5a5a0000;
  endfunction

  // request side of the memory model
  always @(posedge clk) begin
    if (!rst && mem_req_valid && mem_req_ready) begin
      if (mem_we) mem[mem_addr] = mem_wdata;
      else rsp_q.push_back(mem_read(mem_addr));
    end
  end

  // random ready and in-order responses after a random delay
  always @(negedge clk) begin
    mem_req_ready = (lcg_step(mem_seed) % 3) != 0;
    mem_rsp_valid = 1'b0;
    if (rsp_q.size() > 0) begin
      if (rsp_delay == 0) begin
        mem_rsp_valid = 1'b1;
        mem_rdata     = rsp_q.pop_front();
        rsp_delay     = lcg_step(mem_seed) % 4;
      end else begin
        rsp_delay--;
      end
    end
  end

  // later commands are skipped once a wait has run out
  task automatic note_timeout(string what);
    $display("timeout while waiting for %s", what);
    timed_out = 1'b1;
  endtask

  task automatic run_cmd(reg_op_t op, slot_t slot, step_t step, logic is_ptr, data_t val);
    int   i;
    logic hit;
    if (!timed_out) begin
      @(negedge clk);
      cmd_valid  = 1'b1;
      cmd_op     = op;
      cmd_slot   = slot;
      cmd_step   = step;
      cmd_is_ptr = is_ptr;
      cmd_value  = val;
      hit = 1'b0;
      for (i = 0; i < WAIT_LIMIT && !hit; i++) begin
        @(posedge clk);
        hit = cmd_ready;
      end
      if (!hit) begin
        note_timeout("cmd_ready");
      end else begin
        @(negedge clk);
        cmd_valid = 1'b0;
        hit = 1'b0;
        for (i = 0; i < WAIT_LIMIT && !hit; i++) begin
          @(posedge clk);
          hit = op_done;
        end
        if (!hit) note_timeout("op_done");
        else issued++;
      end
    end
  endtask

  initial begin
    int     i;
    int     s;
    int     p;
    data_t  ptrs [4];
    step_t  steps [3];
    data_t  w;
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd_op = op_catch;
    cmd_slot = '0;
    cmd_step = step_none;
    cmd_is_ptr = 1'b0;
    cmd_value = '0;
    // code below 6 and data up to 11 with fixed from 12
    base_code = 32'h1000_0000;
    base_data = 32'h2000_0000;
    data_start = 32'd6;
    fixed_start = 32'd12;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata = '0;
    ptrs = '{32'd3, 32'd8, 32'd20, 32'h0000_0100};
    steps = '{step_none, step_inc, step_dec};
    repeat (2) @(negedge clk);
    rst = 1'b0;
    // catches
    for (i = 0; i < 3; i++) run_cmd(op_catch, 0, step_none, 1'b0, rand_word());
    // slot reads over all three regions
    for (s = 0; s < 16; s++) run_cmd(op_read, slot_t'(s), step_none, 1'b0, '0);
    // indirect reads below, between and above the boundaries
    for (i = 0; i < 4; i++) begin
      run_cmd(op_catch, 0, step_none, 1'b1, ptrs[i]);
      run_cmd(op_read_p, 0, step_none, 1'b0, '0);
    end
    // slot writes with every step and a read back
    for (p = 0; p < 2; p++) begin
      for (i = 0; i < 3; i++) begin
        s = 3 + 4 * i + p;
        run_cmd(op_catch, 0, step_none, 1'b1, ptrs[i]);
        run_cmd(op_catch, 0, step_none, 1'b0, rand_word());
        run_cmd(op_write, slot_t'(s), steps[i], p[0], '0);
        run_cmd(op_read, slot_t'(s), step_none, 1'b0, '0);
      end
    end
    // write through pointer and read back
    for (i = 0; i < 4; i++) begin
      run_cmd(op_catch, 0, step_none, 1'b1, ptrs[i]);
      run_cmd(op_catch, 0, step_none, 1'b0, rand_word());
      run_cmd(op_write_p, 0, step_inc, 1'b0, '0);
      run_cmd(op_read_p, 0, step_none, 1'b0, '0);
    end
    // random mix with mostly small pointers
    for (i = 0; i < 60; i++) begin
      w = rand_word();
      if (lcg_step(stim_seed) % 4 != 0) w = w & 32'h1f;
      run_cmd(reg_op_t'(lcg_step(stim_seed) % 5), slot_t'(lcg_step(stim_seed)),
              step_t'(lcg_step(stim_seed) % 3), lcg_step(stim_seed) % 2, w);
    end
    repeat (4) @(negedge clk);
    $display("commands %0d done %0d errors %0d", issued, done_count, err_count);
    if (!timed_out && err_count == 0 && done_count == issued) begin
      $display("TB PASSED");
    end else begin
      if (timed_out) $display("run stopped early after a timeout");
      if (done_count != issued) $display("op_done count differs from the number of commands");
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+common
common/regmgr_pkg.sv
common/reg_ctrl_if.sv
source/regmgr_fsm.sv
source/addr_translate.sv
source/operand_regs.sv
source/regmgr_top.sv
bench/tb_checker.sv
bench/tb_regmgr_top.sv

//--- Bender.yml
package:
  name: regmgr

sources:
  - include_dirs:
      - common
    files:
      - common/regmgr_pkg.sv
      - common/reg_ctrl_if.sv
      - source/regmgr_fsm.sv
      - source/addr_translate.sv
      - source/operand_regs.sv
      - source/regmgr_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/tb_checker.sv
      - bench/tb_regmgr_top.sv
